// File: mesh_router.f
src/mesh_router_pkg.sv
src/router_input_port.sv
src/router_output_arbiter.sv
src/router_profiler.sv
src/mesh_router.sv
verification/router_checker.sv
verification/mesh_router_tb.sv

// File: verification/mesh_router_tests.txt
# flit line: test src(P/W/E/N/S) dest_x dest_y data(hex) gap_cycles
# stat line: test stats
stats_idle stats
route_basic P 1 2 1001 0
route_basic W 3 2 1002 0
route_basic E 2 1 1003 0
route_basic N 2 3 1004 0
route_basic S 2 2 1005 0
route_basic P 0 7 1006 1
route_basic W 2 0 1007 2
route_basic E 5 2 1008 0
order_stream W 4 2 2001 0
order_stream W 4 2 2002 0
order_stream W 4 3 2003 0
order_stream W 3 0 2004 0
order_stream W 4 2 2005 0
order_stream W 9 1 2006 0
contention P 2 0 3001 0
contention W 2 1 3002 0
contention E 2 0 3003 0
contention S 2 1 3004 0
contention P 2 1 3005 0
contention W 2 0 3006 0
contention E 2 1 3007 0
contention S 2 0 3008 0
stats_traffic stats

// File: verification/mesh_router_tb.sv
module mesh_router_tb;
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct {
    logic [3:0]  dx;
    logic [3:0]  dy;
    logic [15:0] data;
    int          gap;
  } flit_t;

  logic clk_i = 1'b0;
  logic reset_i;
  logic [4:0] link_v_i, link_ready_o, link_v_o, link_ready_i;
  logic [4:0][23:0] link_data_i, link_data_o;
  logic print_stat_v_i, stat_v_o, stat_ready_i;
  logic [3:0] stat_dir_o;
  logic [15:0] stat_idle_o, stat_utilized_o, stat_stalled_o, stat_arbitrated_o;
  logic [31:0] rng = 32'd14619;

  // parsed tests file, one entry per line
  string names[$];
  bit is_stat[$];
  int srcs[$];
  flit_t flits[$];
  flit_t src_q [5][$];

  mesh_router dut_i (
    .clk_i, .reset_i, .my_x_i(4'd2), .my_y_i(4'd2),
    .link_v_i, .link_data_i, .link_ready_o, .link_v_o, .link_data_o, .link_ready_i,
    .print_stat_v_i, .stat_v_o, .stat_dir_o, .stat_idle_o, .stat_utilized_o,
    .stat_stalled_o, .stat_arbitrated_o, .stat_ready_i
  );

  router_checker chk_i (
    .clk_i, .reset_i, .link_v_i, .link_data_i, .link_ready_o_i(link_ready_o),
    .link_v_o_i(link_v_o), .link_data_o_i(link_data_o), .link_ready_i,
    .print_stat_v_i, .stat_v_i(stat_v_o), .stat_dir_i(stat_dir_o),
    .stat_idle_i(stat_idle_o), .stat_utilized_i(stat_utilized_o),
    .stat_stalled_i(stat_stalled_o), .stat_arbitrated_i(stat_arbitrated_o), .stat_ready_i
  );

  initial forever #5 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] v);
    v ^= v << 13;
    v ^= v >> 17;
    v ^= v << 5;
    return v;
  endfunction

  // roughly three cycles in four are ready
  always @(negedge clk_i) begin
    rng = xorshift(rng);
    for (int d = 0; d < 5; d++) link_ready_i[d] = (rng[2*d +: 2] != 2'b00);
    stat_ready_i = (rng[13:12] != 2'b00);
  end

  function automatic int dir_code(input string k);
    case (k)
      "P": return 0;
      "W": return 1;
      "E": return 2;
      "N": return 3;
      "S": return 4;
      default: return -1;
    endcase
  endfunction

  task automatic drive_source(input int s);
    flit_t f;
    forever begin
      while (src_q[s].size() == 0) @(negedge clk_i);
      f = src_q[s].pop_front();
      link_v_i[s] = 1'b1;
      link_data_i[s] = {f.dy, f.dx, f.data};
      while (!link_ready_o[s]) @(negedge clk_i);
      @(negedge clk_i);
      link_v_i[s] = 1'b0;
      repeat (f.gap) @(negedge clk_i);
    end
  endtask

  task automatic wait_drained();
    bit busy;
    busy = 1'b1;
    while (busy) begin
      @(negedge clk_i);
      busy = (link_v_i != '0) || (chk_i.pending() != 0);
      for (int s = 0; s < 5; s++) busy |= (src_q[s].size() != 0);
    end
  endtask

  task automatic request_stats();
    @(negedge clk_i);
    print_stat_v_i = 1'b1;
    // second pulse lands while the stream runs
    @(negedge clk_i);
    @(negedge clk_i);
    print_stat_v_i = 1'b0;
    while (stat_v_o) @(negedge clk_i);
  endtask

  initial begin
    int fd, n, x, y, dat, gap, flit_lines;
    string txt, nm, kw, prev;
    flit_t f;
    reset_i = 1'b1;
    link_v_i = '0;
    link_data_i = '0;
    link_ready_i = '1;
    print_stat_v_i = 1'b0;
    stat_ready_i = 1'b1;
    flit_lines = 0;
    fd = $fopen("verification/mesh_router_tests.txt", "r");
    if (fd == 0) begin
      chk_i.note_error("could not open the tests file");
    end else begin
      while (!$feof(fd)) begin
        txt = "";
        void'($fgets(txt, fd));
        if (txt.len() < 3 || txt[0] == "#") continue;
        n = $sscanf(txt, "%s %s %d %d %h %d", nm, kw, x, y, dat, gap);
        if (kw != "stats" && n != 6) begin
          chk_i.note_error($sformatf("flit line of test %s has missing fields", nm));
        end
        f.dx = 4'(x);
        f.dy = 4'(y);
        f.data = 16'(dat);
        f.gap = gap;
        names.push_back(nm);
        is_stat.push_back(kw == "stats");
        srcs.push_back(dir_code(kw));
        flits.push_back(f);
        if (kw != "stats") flit_lines++;
      end
      $fclose(fd);
    end

    // watchdog sized by the number of flit lines
    fork
      begin
        repeat (200 * flit_lines + 1000) @(posedge clk_i);
        $display("timeout with %0d flits still inside the router", chk_i.pending());
        $display("Verification failed");
        $finish;
      end
    join_none

    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    for (int s = 0; s < 5; s++) begin
      automatic int k = s;
      fork
        drive_source(k);
      join_none
    end

    prev = "";
    for (int i = 0; i < names.size(); i++) begin
      if (names[i] != prev) begin
        if (prev != "") begin
          wait_drained();
          chk_i.finish_test();
        end
        chk_i.start_test(names[i]);
        prev = names[i];
      end
      if (is_stat[i]) begin
        wait_drained();
        request_stats();
      end else if (srcs[i] < 0) begin
        chk_i.note_error($sformatf("unknown source direction in test %s", names[i]));
      end else begin
        src_q[srcs[i]].push_back(flits[i]);
      end
    end
    wait_drained();
    chk_i.finish_test();
    repeat (4) @(negedge clk_i);
    if (chk_i.all_passed()) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: verification/router_checker.sv
module router_checker #(
  parameter int flit_width_p = 24,
  parameter int data_width_p = 16,
  parameter int cord_width_p = 4,
  parameter int stat_width_p = 16,
  parameter int my_x_p = 2,
  parameter int my_y_p = 2
) (
  input logic                         clk_i,
  input logic                         reset_i,
  input logic [4:0]                   link_v_i,
  input logic [4:0][flit_width_p-1:0] link_data_i,
  input logic [4:0]                   link_ready_o_i,
  input logic [4:0]                   link_v_o_i,
  input logic [4:0][flit_width_p-1:0] link_data_o_i,
  input logic [4:0]                   link_ready_i,
  input logic                         print_stat_v_i,
  input logic                         stat_v_i,
  input logic [3:0]                   stat_dir_i,
  input logic [stat_width_p-1:0]      stat_idle_i,
  input logic [stat_width_p-1:0]      stat_utilized_i,
  input logic [stat_width_p-1:0]      stat_stalled_i,
  input logic [stat_width_p-1:0]      stat_arbitrated_i,
  input logic                         stat_ready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // flits held in each input FIFO in arrival order
  logic [flit_width_p-1:0] src_q [5][$];
  int head_dir [5];
  // owe[out][served][waiting]
  bit owe [5][5][5];
  bit hold_pend [5];
  logic [flit_width_p-1:0] hold_data [5];
  int xfer_cnt [5];
  int arb_cnt [5];
  int snap_util [5];
  int snap_arb [5];
  int inj_cnt, snap_inj, snap_cyc, cyc, rec_left;
  int test_errs, pass_cnt, fail_cnt;
  bit first_cyc = 1'b1;
  string cur_test = "reset_state";

  // x first, then y; smaller y is north
  function automatic int expected_dir(input logic [flit_width_p-1:0] f);
    int dx;
    int dy;
    dx = f[data_width_p +: cord_width_p];
    dy = f[data_width_p + cord_width_p +: cord_width_p];
    if (dx == my_x_p && dy == my_y_p) return 0;
    if (dx != my_x_p) return (dx < my_x_p) ? 1 : 2;
    return (dy < my_y_p) ? 3 : 4;
  endfunction

  // number of input heads that want output d this cycle
  function automatic int heads_for(input int d);
    int n;
    n = 0;
    for (int r = 0; r < 5; r++) begin
      if (head_dir[r] == d) n++;
    end
    return n;
  endfunction

  task automatic note_error(input string msg);
    $display("%s", msg);
    test_errs++;
  endtask

  task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("Mismatch %s: %s expected %0h actual %0h", cur_test, what, exp, act);
    test_errs++;
  endtask

  task automatic take_flit(input int d);
    int s;
    int w;
    logic [flit_width_p-1:0] act;
    act = link_data_o_i[d];
    s = -1;
    w = -1;
    for (int r = 0; r < 5; r++) begin
      if (head_dir[r] == d && w < 0) w = r;
      if (head_dir[r] == d && s < 0 && src_q[r][0] == act) s = r;
    end
    if (s < 0) begin
      if (w >= 0) mismatch($sformatf("flit on output %0d", d), src_q[w][0], act);
      else note_error($sformatf("unexpected flit %h left on output %0d", act, d));
      return;
    end
    for (int r = 0; r < 5; r++) begin
      if (owe[d][s][r]) begin
        note_error($sformatf(
          "unfair arbitration in %s: input %0d served twice on output %0d while input %0d waited",
          cur_test, s, d, r));
      end
    end
    for (int r = 0; r < 5; r++) begin
      owe[d][r][s] = 1'b0;
      owe[d][s][r] = (r != s) && (head_dir[r] == d);
    end
    void'(src_q[s].pop_front());
  endtask

  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (first_cyc && (link_v_o_i != '0 || stat_v_i || link_ready_o_i != '1)) begin
        note_error("outputs were not in their idle state after reset");
      end
      first_cyc = 1'b0;
      cyc++;
      // heads seen by the arbiters this cycle
      for (int r = 0; r < 5; r++) begin
        head_dir[r] = (src_q[r].size() != 0) ? expected_dir(src_q[r][0]) : -1;
      end
      for (int d = 0; d < 5; d++) begin
        if (hold_pend[d] && !link_v_o_i[d]) begin
          note_error($sformatf("output %0d dropped its valid before ready in %s", d, cur_test));
        end else if (hold_pend[d] && link_data_o_i[d] != hold_data[d]) begin
          mismatch($sformatf("held data on output %0d", d), hold_data[d], link_data_o_i[d]);
        end
        if (link_v_o_i[d] && link_ready_i[d]) begin
          xfer_cnt[d]++;
          // a transfer with more than one requester
          if (heads_for(d) > 1) arb_cnt[d]++;
          take_flit(d);
        end
        hold_pend[d] = link_v_o_i[d] && !link_ready_i[d];
        hold_data[d] = link_data_o_i[d];
      end
      for (int s = 0; s < 5; s++) begin
        if (link_v_i[s] && link_ready_o_i[s]) begin
          src_q[s].push_back(link_data_i[s]);
          if (s == 0) inj_cnt++;
        end
      end
      if (stat_v_i && stat_ready_i) begin
        if (rec_left == 0) begin
          note_error($sformatf("stat record appeared with no request pending in %s", cur_test));
        end else begin
          int idx;
          idx = 6 - rec_left;
          check_record(idx);
          rec_left--;
        end
      end else if (print_stat_v_i && rec_left == 0) begin
        // the snapshot includes this cycle
        for (int d = 0; d < 5; d++) begin
          snap_util[d] = xfer_cnt[d];
          snap_arb[d] = arb_cnt[d];
        end
        snap_inj = inj_cnt;
        snap_cyc = cyc;
        rec_left = 6;
      end
    end
  end

  task automatic check_record(input int idx);
    int exp_dir;
    int exp_util;
    int sum;
    exp_dir = (idx < 5) ? idx : 15;
    exp_util = (idx < 5) ? snap_util[idx] : snap_inj;
    sum = int'(stat_idle_i) + int'(stat_utilized_i) + int'(stat_stalled_i);
    if (stat_dir_i != exp_dir) mismatch("stat direction", exp_dir, stat_dir_i);
    if (stat_utilized_i != exp_util) mismatch($sformatf("utilized of record %0d", exp_dir),
                                              exp_util, stat_utilized_i);
    if (sum != snap_cyc) mismatch($sformatf("cycle total of record %0d", exp_dir), snap_cyc, sum);
    if (idx < 5 && stat_arbitrated_i != snap_arb[idx]) begin
      mismatch($sformatf("arbitrated of record %0d", exp_dir), snap_arb[idx],
               stat_arbitrated_i);
    end
  endtask

  function automatic int pending();
    int n;
    n = 0;
    for (int s = 0; s < 5; s++) n += src_q[s].size();
    return n;
  endfunction

  task automatic start_test(input string name);
    cur_test = name;
  endtask

  task automatic finish_test();
    if (rec_left != 0) note_error($sformatf("stat stream of %s ended early", cur_test));
    rec_left = 0;
    if (test_errs == 0) pass_cnt++;
    else fail_cnt++;
    $display("test %s: %s", cur_test, (test_errs == 0) ? "ok" : "FAILED");
    test_errs = 0;
  endtask

  function automatic bit all_passed();
    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    return (fail_cnt == 0) && (test_errs == 0);
  endfunction

endmodule

// File: src/mesh_router.sv
module mesh_router #(
  parameter int x_cord_width_p = 4,
  parameter int y_cord_width_p = 4,
  parameter int data_width_p = 16,
  parameter int fifo_depth_p = 2,
  parameter int xy_order_p = 1,
  parameter int stat_width_p = 16,
  localparam int flit_width_lp = y_cord_width_p + x_cord_width_p + data_width_p
) (
  input  logic                                                      clk_i,
  input  logic                                                      reset_i,
  input  logic [x_cord_width_p-1:0]                                 my_x_i,
  input  logic [y_cord_width_p-1:0]                                 my_y_i,

  input  logic [mesh_router_pkg::num_dirs_c-1:0]                    link_v_i,
  input  logic [mesh_router_pkg::num_dirs_c-1:0][flit_width_lp-1:0] link_data_i,
  output logic [mesh_router_pkg::num_dirs_c-1:0]                    link_ready_o,

  output logic [mesh_router_pkg::num_dirs_c-1:0]                    link_v_o,
  output logic [mesh_router_pkg::num_dirs_c-1:0][flit_width_lp-1:0] link_data_o,
  input  logic [mesh_router_pkg::num_dirs_c-1:0]                    link_ready_i,

  input  logic                                                      print_stat_v_i,
  output logic                                                      stat_v_o,
  output logic [mesh_router_pkg::stat_dir_width_c-1:0]              stat_dir_o,
  output logic [stat_width_p-1:0]                                   stat_idle_o,
  output logic [stat_width_p-1:0]                                   stat_utilized_o,
  output logic [stat_width_p-1:0]                                   stat_stalled_o,
  output logic [stat_width_p-1:0]                                   stat_arbitrated_o,
  input  logic                                                      stat_ready_i
);
  import mesh_router_pkg::*;

  logic [num_dirs_c-1:0]                    head_v;
  logic [num_dirs_c-1:0][flit_width_lp-1:0] head_data;
  logic [num_dirs_c-1:0]                    pop;

  // route_req[input][output], req_t[output][input]
  logic [num_dirs_c-1:0][num_dirs_c-1:0]    route_req;
  logic [num_dirs_c-1:0][num_dirs_c-1:0]    req_t;
  // grant[output][input], grant_t[input][output]
  logic [num_dirs_c-1:0][num_dirs_c-1:0]    grant;
  logic [num_dirs_c-1:0][num_dirs_c-1:0]    grant_t;

  logic [num_dirs_c-1:0]                    xfer;
  logic                                     inj_head_blocked;

  for (genvar i = 0; i < num_dirs_c; i++) begin : g_in
    router_input_port #(
      .x_cord_width_p(x_cord_width_p),
      .y_cord_width_p(y_cord_width_p),
      .data_width_p  (data_width_p),
      .fifo_depth_p  (fifo_depth_p),
      .xy_order_p    (xy_order_p)
    ) in_port_i (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .my_x_i      (my_x_i),
      .my_y_i      (my_y_i),
      .link_v_i    (link_v_i[i]),
      .link_data_i (link_data_i[i]),
      .pop_i       (pop[i]),
      .link_ready_o(link_ready_o[i]),
      .head_v_o    (head_v[i]),
      .head_data_o (head_data[i]),
      .route_req_o (route_req[i])
    );

    // pop when granted by an output whose link is ready
    assign pop[i] = head_v[i] & ((grant_t[i] & link_ready_i) != '0);
  end

  for (genvar d = 0; d < num_dirs_c; d++) begin : g_out
    for (genvar i = 0; i < num_dirs_c; i++) begin : g_xpose
      assign req_t[d][i]   = route_req[i][d];
      assign grant_t[i][d] = grant[d][i];
    end

    router_output_arbiter #(
      .flit_width_p(flit_width_lp)
    ) out_arb_i (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .req_i       (req_t[d]),
      .head_data_i (head_data),
      .link_ready_i(link_ready_i[d]),
      .grant_o     (grant[d]),
      .link_v_o    (link_v_o[d]),
      .link_data_o (link_data_o[d])
    );

    assign xfer[d] = link_v_o[d] & link_ready_i[d];
  end

  // local head waiting while its ready output serves someone else
  assign inj_head_blocked = head_v[P] && (grant_t[P] == '0)
                          && ((route_req[P] & link_ready_i) != '0);

  router_profiler #(
    .stat_width_p(stat_width_p)
  ) profiler_i (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .req_matrix_i      (req_t),
    .xfer_i            (xfer),
    .inj_v_i           (link_v_i[P]),
    .inj_ready_i       (link_ready_o[P]),
    .inj_head_blocked_i(inj_head_blocked),
    .print_stat_v_i    (print_stat_v_i),
    .stat_ready_i      (stat_ready_i),
    .stat_v_o          (stat_v_o),
    .stat_dir_o        (stat_dir_o),
    .stat_idle_o       (stat_idle_o),
    .stat_utilized_o   (stat_utilized_o),
    .stat_stalled_o    (stat_stalled_o),
    .stat_arbitrated_o (stat_arbitrated_o)
  );

endmodule

// File: src/router_profiler.sv
module router_profiler #(
  parameter int stat_width_p = 16
) (
  input  logic                                                                clk_i,
  input  logic                                                                reset_i,
  input  logic [mesh_router_pkg::num_dirs_c-1:0][mesh_router_pkg::num_dirs_c-1:0]
                                                                              req_matrix_i,
  input  logic [mesh_router_pkg::num_dirs_c-1:0]                              xfer_i,
  input  logic                                                                inj_v_i,
  input  logic                                                                inj_ready_i,
  input  logic                                                                inj_head_blocked_i,
  input  logic                                                                print_stat_v_i,
  input  logic                                                                stat_ready_i,
  output logic                                                                stat_v_o,
  output logic [mesh_router_pkg::stat_dir_width_c-1:0]                        stat_dir_o,
  output logic [stat_width_p-1:0]                                             stat_idle_o,
  output logic [stat_width_p-1:0]                                             stat_utilized_o,
  output logic [stat_width_p-1:0]                                             stat_stalled_o,
  output logic [stat_width_p-1:0]                                             stat_arbitrated_o
);
  import mesh_router_pkg::*;

  typedef logic [num_stat_records_c-1:0][stat_width_p-1:0] ctr_bank_t;

  // live counters and their next values
  ctr_bank_t idle_r, util_r, stall_r, arb_r;
  ctr_bank_t idle_n, util_n, stall_n, arb_n;

  // snapshot bank
  ctr_bank_t snap_idle_r, snap_util_r, snap_stall_r, snap_arb_r;

  logic [num_stat_records_c-1:0] idle_ev, util_ev, stall_ev, arb_ev;
  logic [stat_idx_width_c-1:0]   rec_idx_r;
  logic                          start;
  logic                          rec_done;

  function automatic logic [stat_width_p-1:0] sat_inc(
    input logic [stat_width_p-1:0] val,
    input logic                    en
  );
    sat_inc = (en && (val != '1)) ? val + 1'b1 : val;
  endfunction

  // one event of idle, utilized, stalled per slot and cycle
  always_comb begin
    for (int d = 0; d < num_dirs_c; d++) begin
      idle_ev[d]  = (req_matrix_i[d] == '0);
      util_ev[d]  = xfer_i[d];
      stall_ev[d] = (req_matrix_i[d] != '0) && !xfer_i[d];
      // more than one bit set
      arb_ev[d]   = ((req_matrix_i[d] & (req_matrix_i[d] - 1'b1)) != '0) && xfer_i[d];
    end
    idle_ev[inject_record_idx_c]  = ~inj_v_i;
    util_ev[inject_record_idx_c]  = inj_v_i & inj_ready_i;
    stall_ev[inject_record_idx_c] = inj_v_i & ~inj_ready_i;
    arb_ev[inject_record_idx_c]   = inj_head_blocked_i;
  end

  always_comb begin
    for (int s = 0; s < num_stat_records_c; s++) begin
      idle_n[s]  = sat_inc(idle_r[s], idle_ev[s]);
      util_n[s]  = sat_inc(util_r[s], util_ev[s]);
      stall_n[s] = sat_inc(stall_r[s], stall_ev[s]);
      arb_n[s]   = sat_inc(arb_r[s], arb_ev[s]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      idle_r  <= '0;
      util_r  <= '0;
      stall_r <= '0;
      arb_r   <= '0;
    end else begin
      idle_r  <= idle_n;
      util_r  <= util_n;
      stall_r <= stall_n;
      arb_r   <= arb_n;
    end
  end

  // requests during a stream are dropped
  assign start    = print_stat_v_i & ~stat_v_o;
  assign rec_done = stat_v_o & stat_ready_i;

  // snapshot includes the request cycle itself
  always_ff @(posedge clk_i) begin
    if (start) begin
      snap_idle_r  <= idle_n;
      snap_util_r  <= util_n;
      snap_stall_r <= stall_n;
      snap_arb_r   <= arb_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stat_v_o  <= 1'b0;
      rec_idx_r <= '0;
    end else if (start) begin
      stat_v_o  <= 1'b1;
      rec_idx_r <= '0;
    end else if (rec_done) begin
      if (rec_idx_r == stat_idx_width_c'(inject_record_idx_c)) begin
        stat_v_o  <= 1'b0;
        rec_idx_r <= '0;
      end else begin
        rec_idx_r <= rec_idx_r + 1'b1;
      end
    end
  end

  assign stat_dir_o = (rec_idx_r == stat_idx_width_c'(inject_record_idx_c))
                    ? stat_dir_width_c'(inject_dir_code_c)
                    : stat_dir_width_c'(rec_idx_r);

  assign stat_idle_o       = snap_idle_r[rec_idx_r];
  assign stat_utilized_o   = snap_util_r[rec_idx_r];
  assign stat_stalled_o    = snap_stall_r[rec_idx_r];
  assign stat_arbitrated_o = snap_arb_r[rec_idx_r];

endmodule

// File: src/router_output_arbiter.sv
module router_output_arbiter #(
  parameter int flit_width_p = 24
) (
  input  logic                                                      clk_i,
  input  logic                                                      reset_i,
  input  logic [mesh_router_pkg::num_dirs_c-1:0]                    req_i,
  input  logic [mesh_router_pkg::num_dirs_c-1:0][flit_width_p-1:0]  head_data_i,
  input  logic                                                      link_ready_i,
  output logic [mesh_router_pkg::num_dirs_c-1:0]                    grant_o,
  output logic                                                      link_v_o,
  output logic [flit_width_p-1:0]                                   link_data_o
);
  import mesh_router_pkg::*;

  // lock state while the downstream stalls
  logic                       lock_r;
  logic [dir_idx_width_c-1:0] lock_idx_r;

  // last input that completed a transfer
  logic [dir_idx_width_c-1:0] last_r;

  logic [dir_idx_width_c-1:0] rr_idx;
  logic                       rr_found;
  logic [dir_idx_width_c-1:0] sel_idx;
  logic                       any_req;
  logic                       xfer;

  assign any_req = |req_i;

  // round-robin search starting after the last winner
  always_comb begin
    int cand;
    rr_idx   = '0;
    rr_found = 1'b0;
    for (int off = 1; off <= num_dirs_c; off++) begin
      cand = int'(last_r) + off;
      if (cand >= num_dirs_c) begin
        cand = cand - num_dirs_c;
      end
      if (!rr_found && req_i[cand]) begin
        rr_found = 1'b1;
        rr_idx   = dir_idx_width_c'(cand);
      end
    end
  end

  // a stalled transfer keeps its winner
  assign sel_idx = lock_r ? lock_idx_r : rr_idx;

  always_comb begin
    grant_o = '0;
    grant_o[sel_idx] = any_req;
  end

  assign link_v_o    = any_req;
  assign link_data_o = head_data_i[sel_idx];
  assign xfer        = link_v_o & link_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_r <= 1'b0;
      last_r <= dir_idx_width_c'(num_dirs_c - 1);
    end else begin
      lock_r <= link_v_o & ~link_ready_i;
      // pointer moves only on a completed handshake
      if (xfer) begin
        last_r <= sel_idx;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    lock_idx_r <= sel_idx;
  end

endmodule

// File: src/router_input_port.sv
module router_input_port #(
  parameter int x_cord_width_p = 4,
  parameter int y_cord_width_p = 4,
  parameter int data_width_p = 16,
  parameter int fifo_depth_p = 2,
  parameter int xy_order_p = 1,
  localparam int flit_width_lp = y_cord_width_p + x_cord_width_p + data_width_p
) (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic [x_cord_width_p-1:0]              my_x_i,
  input  logic [y_cord_width_p-1:0]              my_y_i,
  input  logic                                   link_v_i,
  input  logic [flit_width_lp-1:0]               link_data_i,
  input  logic                                   pop_i,
  output logic                                   link_ready_o,
  output logic                                   head_v_o,
  output logic [flit_width_lp-1:0]               head_data_o,
  output logic [mesh_router_pkg::num_dirs_c-1:0] route_req_o
);
  import mesh_router_pkg::*;

  localparam int addr_width_lp = $clog2(fifo_depth_p);

  logic [flit_width_lp-1:0] mem_r [fifo_depth_p];
  // extra msb tells full from empty
  logic [addr_width_lp:0]   wr_ptr_r;
  logic [addr_width_lp:0]   rd_ptr_r;
  logic                     fifo_empty;
  logic                     fifo_full;
  logic                     enq;
  logic                     deq;

  logic [x_cord_width_p-1:0] dest_x;
  logic [y_cord_width_p-1:0] dest_y;
  logic                      x_match;
  logic                      y_match;
  dir_e                      x_dir;
  dir_e                      y_dir;
  dir_e                      route_dir;

  assign fifo_empty = (wr_ptr_r == rd_ptr_r);
  assign fifo_full  = (wr_ptr_r[addr_width_lp] != rd_ptr_r[addr_width_lp])
                    && (wr_ptr_r[addr_width_lp-1:0] == rd_ptr_r[addr_width_lp-1:0]);

  assign link_ready_o = ~fifo_full;
  assign enq = link_v_i & link_ready_o;
  assign deq = pop_i & head_v_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
    end else begin
      if (enq) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (deq) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
    end
  end

  // flit storage
  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r[addr_width_lp-1:0]] <= link_data_i;
    end
  end

  assign head_v_o    = ~fifo_empty;
  assign head_data_o = mem_r[rd_ptr_r[addr_width_lp-1:0]];

  // destination fields of the head flit
  assign dest_x = head_data_o[data_width_p +: x_cord_width_p];
  assign dest_y = head_data_o[data_width_p + x_cord_width_p +: y_cord_width_p];

  assign x_match = (dest_x == my_x_i);
  assign y_match = (dest_y == my_y_i);

  // smaller y lies to the north
  assign x_dir = (dest_x < my_x_i) ? W : E;
  assign y_dir = (dest_y < my_y_i) ? N : S;

  // dimension-ordered route
  always_comb begin
    if (x_match && y_match) begin
      route_dir = P;
    end else if (xy_order_p != 0) begin
      route_dir = x_match ? y_dir : x_dir;
    end else begin
      route_dir = y_match ? x_dir : y_dir;
    end
  end

  always_comb begin
    route_req_o = '0;
    route_req_o[route_dir] = head_v_o;
  end

endmodule

// File: src/mesh_router_pkg.sv
package mesh_router_pkg;

  // port directions
  // P is the local processor port, the rest are mesh neighbours
  typedef enum logic [2:0] {
    P = 3'd0,
    W = 3'd1,
    E = 3'd2,
    N = 3'd3,
    S = 3'd4
  } dir_e;

  // number of router ports
  localparam int num_dirs_c = 5;

  // width of a port index
  localparam int dir_idx_width_c = $clog2(num_dirs_c);

  // stat record direction field
  localparam int stat_dir_width_c = 4;

  // direction code of the injection port record
  // kept clear of the five real directions
  localparam int inject_dir_code_c = 15;

  // one record per output, then the injection record
  localparam int num_stat_records_c = num_dirs_c + 1;

  // index of the injection record in the stream
  localparam int inject_record_idx_c = num_dirs_c;

  // record counter width
  localparam int stat_idx_width_c = $clog2(num_stat_records_c);

  // flit layout is {dest_y, dest_x, data}
  localparam int flit_num_fields_c = 3;

endpackage
